/* byte_bank.sv */
// One byte lane of the data memory
// 64 x 8 synchronous RAM with a write port and a registered read port.
// A write and a read of the same row in one cycle return the old byte.

`default_nettype none

module byte_bank (
    input  logic                                clk,
    input  logic                                i_we,
    input  logic                                i_re,
    input  logic [mem_pkg::ROW_ADDR_WIDTH-1:0] i_waddr,
    input  logic [mem_pkg::ROW_ADDR_WIDTH-1:0] i_raddr,
    input  logic [mem_pkg::LANE_WIDTH-1:0]     i_din,
    output logic [mem_pkg::LANE_WIDTH-1:0]     o_dout
);

    import mem_pkg::*;

    // Storage, one byte per row
    logic [LANE_WIDTH-1:0] mem [0:(1 << ROW_ADDR_WIDTH)-1];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_din;
        end
    end

    // Read register holds its value while i_re is low
    always_ff @(posedge clk) begin
        if (i_re) begin
            o_dout <= mem[i_raddr];
        end
    end

    // A lane write must land on a known row
    a_waddr_known: assert property (
        @(posedge clk) i_we |-> !$isunknown(i_waddr)
    ) else $error("byte_bank write with unknown row address");

endmodule

`default_nettype wire

/* byte_lane_memory.sv */
// Byte-addressed data memory, 256 bytes in four byte-wide banks
// Byte, halfword and word accesses at any address, with row wrap at the
// top. Writes land at the clock edge, reads return one cycle later.

`default_nettype none

module byte_lane_memory (
    input  logic                                clk,
    input  logic                                i_reset,
    input  logic                                i_wen,
    input  logic                                i_ren,
    input  mem_pkg::access_size_t               i_size,
    input  logic [mem_pkg::MEM_ADDR_WIDTH-1:0] i_waddr,
    input  logic [mem_pkg::MEM_ADDR_WIDTH-1:0] i_raddr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     i_din,
    output logic [mem_pkg::DATA_WIDTH-1:0]     o_dout
);

    import mem_pkg::*;

    logic [NUM_LANES-1:0]                      lane_we;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0]      lane_wdata;
    logic [NUM_LANES-1:0][ROW_ADDR_WIDTH-1:0]  lane_waddr;
    logic [NUM_LANES-1:0][ROW_ADDR_WIDTH-1:0]  lane_raddr;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0]      lane_dout;

    // Address and data steering onto the lanes
    lane_steer u_lane_steer (
        .i_wen        (i_wen),
        .i_size       (i_size),
        .i_waddr      (i_waddr),
        .i_raddr      (i_raddr),
        .i_din        (i_din),
        .o_lane_we    (lane_we),
        .o_lane_wdata (lane_wdata),
        .o_lane_waddr (lane_waddr),
        .o_lane_raddr (lane_raddr)
    );

    // One bank per byte lane
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_bank
        byte_bank u_bank (
            .clk     (clk),
            .i_we    (lane_we[g]),
            .i_re    (i_ren),
            .i_waddr (lane_waddr[g]),
            .i_raddr (lane_raddr[g]),
            .i_din   (lane_wdata[g]),
            .o_dout  (lane_dout[g])
        );
    end

    // Put the read bytes back in order
    load_gather u_load_gather (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_ren        (i_ren),
        .i_size       (i_size),
        .i_raddr_lane (i_raddr[LANE_BITS-1:0]),
        .i_lane_dout  (lane_dout),
        .o_dout       (o_dout)
    );

endmodule

`default_nettype wire

/* lane_steer.sv */
// Lane steering for the byte-lane data memory
// Rotates the write bytes onto the lanes that hold them, raises one write
// enable per covered lane and works out the row each lane uses for the
// write and the read, moving low lanes to the next row on an unaligned access

`default_nettype none

module lane_steer (
    input  logic                                                     i_wen,
    input  mem_pkg::access_size_t                                    i_size,
    input  logic [mem_pkg::MEM_ADDR_WIDTH-1:0]                      i_waddr,
    input  logic [mem_pkg::MEM_ADDR_WIDTH-1:0]                      i_raddr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]                          i_din,
    output logic [mem_pkg::NUM_LANES-1:0]                           o_lane_we,
    output logic [mem_pkg::NUM_LANES-1:0][mem_pkg::LANE_WIDTH-1:0]  o_lane_wdata,
    output logic [mem_pkg::NUM_LANES-1:0][mem_pkg::ROW_ADDR_WIDTH-1:0] o_lane_waddr,
    output logic [mem_pkg::NUM_LANES-1:0][mem_pkg::ROW_ADDR_WIDTH-1:0] o_lane_raddr
);

    import mem_pkg::*;

    // Split addresses into row and lane offset
    logic [LANE_BITS-1:0]      w_off;
    logic [LANE_BITS-1:0]      r_off;
    logic [ROW_ADDR_WIDTH-1:0] w_row;
    logic [ROW_ADDR_WIDTH-1:0] w_row_next;
    logic [ROW_ADDR_WIDTH-1:0] r_row;
    logic [ROW_ADDR_WIDTH-1:0] r_row_next;
    logic [LANE_BITS:0]        w_count;

    assign w_off = i_waddr[LANE_BITS-1:0];
    assign r_off = i_raddr[LANE_BITS-1:0];
    assign w_row = i_waddr[MEM_ADDR_WIDTH-1:LANE_BITS];
    assign r_row = i_raddr[MEM_ADDR_WIDTH-1:LANE_BITS];

    // Top row wraps to row 0
    assign w_row_next = w_row + 1'b1;
    assign r_row_next = r_row + 1'b1;

    assign w_count = size_bytes(i_size);

    // Byte k of the access sits in lane (offset + k) mod 4
    always_comb begin
        logic [LANE_BITS-1:0] lane;
        o_lane_we    = '0;
        o_lane_wdata = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            lane               = w_off + LANE_BITS'(k);
            o_lane_wdata[lane] = i_din[k*LANE_WIDTH +: LANE_WIDTH];
            if (i_wen && (k < w_count)) begin
                o_lane_we[lane] = 1'b1;
            end
        end

        // Lane count must match the size code, word being the odd one out
        a_lane_count: assert ($countones(o_lane_we) ==
                              (!i_wen ? 0 :
                               (i_size == SIZE_WORD) ? 4 : int'(i_size)))
            else $error("lane_steer enabled %0d lanes for size %s",
                        $countones(o_lane_we), i_size.name());
    end

    // Lanes below the offset belong to the next row
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (l < w_off) begin
                o_lane_waddr[l] = w_row_next;
            end else begin
                o_lane_waddr[l] = w_row;
            end

            // Read rows for every lane, size sorted out later
            if (l < r_off) begin
                o_lane_raddr[l] = r_row_next;
            end else begin
                o_lane_raddr[l] = r_row;
            end
        end
    end

endmodule

`default_nettype wire

/* load_gather.sv */
// Read data gathering for the byte-lane data memory
// Registers the size and lane offset of each read alongside the bank read,
// then rotates the four bank bytes back into access order and zero-extends
// the result to a full word

`default_nettype none

module load_gather (
    input  logic                                                    clk,
    input  logic                                                    i_reset,
    input  logic                                                    i_ren,
    input  mem_pkg::access_size_t                                   i_size,
    input  logic [mem_pkg::LANE_BITS-1:0]                          i_raddr_lane,
    input  logic [mem_pkg::NUM_LANES-1:0][mem_pkg::LANE_WIDTH-1:0] i_lane_dout,
    output logic [mem_pkg::DATA_WIDTH-1:0]                         o_dout
);

    import mem_pkg::*;

    // Request that the banks are answering this cycle
    access_size_t         size_q;
    logic [LANE_BITS-1:0] off_q;
    logic [LANE_BITS:0]   count_q;

    // Idle edges read as SIZE_NONE so the output drops to zero
    always_ff @(posedge clk) begin
        if (i_reset) begin
            size_q <= SIZE_NONE;
        end else if (i_ren) begin
            size_q <= i_size;
        end else begin
            size_q <= SIZE_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ren) begin
            off_q <= i_raddr_lane;
        end
    end

    assign count_q = size_bytes(size_q);

    // Byte k comes from lane (offset + k) mod 4
    always_comb begin
        logic [LANE_BITS-1:0] lane;
        o_dout = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            lane = off_q + LANE_BITS'(k);
            if (k < count_q) begin
                o_dout[k*LANE_WIDTH +: LANE_WIDTH] = i_lane_dout[lane];
            end
        end
    end

    // A byte load never leaks bank data into the upper bytes
    a_byte_zero_ext: assert property (
        @(posedge clk) disable iff (i_reset)
        (size_q == SIZE_BYTE) |-> (o_dout[DATA_WIDTH-1:LANE_WIDTH] == '0)
    ) else $error("load_gather byte read has nonzero upper bytes");

endmodule

`default_nettype wire

/* mem_pkg.sv */
// Byte-lane data memory package
// Geometry of the 256-byte memory, the access size codes shared by
// the write and read sides, and the byte count of each size

`default_nettype none

package mem_pkg;

    // Byte address into the whole memory
    localparam int MEM_ADDR_WIDTH = 8;

    // Four byte lanes per 32-bit row
    localparam int NUM_LANES = 4;
    localparam int LANE_BITS = 2;

    // Row index inside one bank
    localparam int ROW_ADDR_WIDTH = MEM_ADDR_WIDTH - LANE_BITS;

    localparam int DATA_WIDTH = 32;
    localparam int LANE_WIDTH = 8;

    // Access size, same codes as the core's load/store size field
    typedef enum logic [1:0] {
        SIZE_NONE = 2'd0,
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2,
        SIZE_WORD = 2'd3
    } access_size_t;

    // Number of bytes touched by an access of the given size
    function automatic logic [LANE_BITS:0] size_bytes(input access_size_t size);
        logic [LANE_BITS:0] count;
        case (size)
            SIZE_BYTE: begin
                count = 3'd1;
            end
            SIZE_HALF: begin
                count = 3'd2;
            end
            SIZE_WORD: begin
                count = 3'd4;
            end
            default: begin
                count = 3'd0;
            end
        endcase
        return count;
    endfunction

endpackage

`default_nettype wire

/* sim.f */
mem_pkg.sv
byte_bank.sv
lane_steer.sv
load_gather.sv
byte_lane_memory.sv
tb_clock_gen.sv
tb_checker.sv
tb_memory.sv

/* tb_checker.sv */
// Byte-lane memory checker
// Follows the DUT inputs into a flat 256-byte model with read-first
// ordering and compares o_dout one cycle after every clock edge

`default_nettype none

module tb_checker (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_wen,
    input  logic                                i_ren,
    input  mem_pkg::access_size_t               i_size,
    input  logic [mem_pkg::MEM_ADDR_WIDTH-1:0] i_waddr,
    input  logic [mem_pkg::MEM_ADDR_WIDTH-1:0] i_raddr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     i_din,
    input  logic [mem_pkg::DATA_WIDTH-1:0]     i_dout,
    input  logic [3:0]                          i_test_id,
    input  logic                                i_test_done,
    output logic [31:0]                         o_error_count,
    output logic [31:0]                         o_check_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    // One entry per byte address
    logic [LANE_WIDTH-1:0] model [0:(1 << MEM_ADDR_WIDTH)-1];
    logic [DATA_WIDTH-1:0] expected;
    logic                  pending;
    int                    test_checks;
    int                    test_errors;

    initial begin
        pending       = 1'b0;
        expected      = '0;
        test_checks   = 0;
        test_errors   = 0;
        o_error_count = '0;
        o_check_count = '0;
    end

    function automatic int access_bytes(input access_size_t size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            SIZE_WORD: return 4;
            default:   return 0;
        endcase
    endfunction

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "reset and aligned fill";
            4'd2:    return "random bytes";
            4'd3:    return "unaligned half and word";
            4'd4:    return "size none and idle reads";
            4'd5:    return "back-to-back traffic";
            default: return "unknown";
        endcase
    endfunction

    // Byte k of an access lives at address + k modulo 256
    function automatic logic [DATA_WIDTH-1:0] model_read(
        input logic [MEM_ADDR_WIDTH-1:0] addr,
        input access_size_t              size
    );
        logic [DATA_WIDTH-1:0]     word;
        logic [MEM_ADDR_WIDTH-1:0] a;
        word = '0;
        for (int k = 0; k < access_bytes(size); k++) begin
            a = addr + k[MEM_ADDR_WIDTH-1:0];
            word[k*LANE_WIDTH +: LANE_WIDTH] = model[a];
        end
        return word;
    endfunction

    task automatic model_write(
        input logic [MEM_ADDR_WIDTH-1:0] addr,
        input logic [DATA_WIDTH-1:0]     data,
        input access_size_t              size
    );
        logic [MEM_ADDR_WIDTH-1:0] a;
        for (int k = 0; k < access_bytes(size); k++) begin
            a = addr + k[MEM_ADDR_WIDTH-1:0];
            model[a] = data[k*LANE_WIDTH +: LANE_WIDTH];
        end
    endtask

    // Inputs and o_dout are both stable at the falling edge
    always @(negedge i_clk) begin
        if (pending) begin
            o_check_count = o_check_count + 1;
            test_checks   = test_checks + 1;
            if (i_dout !== expected) begin
                $display("MISMATCH time=%0d ns signal=o_dout expected=%08h actual=%08h",
                         $time, expected, i_dout);
                o_error_count = o_error_count + 1;
                test_errors   = test_errors + 1;
            end
        end

        if (i_test_done) begin
            $display("test %0d (%s) finished: %0d checks, %0d errors",
                     i_test_id, test_name(i_test_id), test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
        end

        // Read sees the bytes before this edge's write
        if (i_reset || !i_ren || (i_size == SIZE_NONE)) begin
            expected = '0;
        end else begin
            expected = model_read(i_raddr, i_size);
        end
        if (i_wen && (i_size != SIZE_NONE)) begin
            model_write(i_waddr, i_din, i_size);
        end
        pending = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Testbench clock and reset source
// 20 ns clock, synchronous reset held high for the first 16 rising edges

`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 16;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) o_clk = ~o_clk;
        end
    end

    // Release lands just after an edge, like the rest of the stimulus
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #2;
        o_reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_memory.sv */
// Testbench top for the byte-lane data memory
// Drives seeded random byte, half and word traffic into the DUT,
// sequences the tests and guards the run with a watchdog

`default_nettype none

module tb_memory;

    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    localparam int CLK_PERIOD_NS   = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_ROWS        = 1 << ROW_ADDR_WIDTH;
    localparam int N_BYTE_OPS      = 300;
    localparam int N_UNALIGNED_OPS = 300;
    localparam int N_NONE_OPS      = 120;
    localparam int N_B2B_OPS       = 200;
    localparam int END_CYCLES      = 3;
    localparam int NUM_TESTS       = 5;
    localparam int TOTAL_OPS       = 2 * NUM_ROWS + N_BYTE_OPS + N_UNALIGNED_OPS
                                   + N_NONE_OPS + N_B2B_OPS + NUM_TESTS * END_CYCLES + 4;
    localparam int WATCHDOG_NS     = TOTAL_OPS * CLK_PERIOD_NS * 2
                                   + RESET_CYCLES * CLK_PERIOD_NS;

    logic                      clk;
    logic                      reset;
    logic                      mem_wen;
    logic                      mem_ren;
    access_size_t              mem_size;
    logic [MEM_ADDR_WIDTH-1:0] mem_waddr;
    logic [MEM_ADDR_WIDTH-1:0] mem_raddr;
    logic [DATA_WIDTH-1:0]     mem_din;
    logic [DATA_WIDTH-1:0]     mem_dout;
    logic [3:0]                test_id;
    logic                      test_done;
    logic [31:0]               error_count;
    logic [31:0]               check_count;
    int                        tests_run;
    integer                    seed = 32'h3266;

    tb_clock_gen u_clock_gen (
        .o_clk   (clk),
        .o_reset (reset)
    );

    byte_lane_memory dut0 (
        .clk     (clk),
        .i_reset (reset),
        .i_wen   (mem_wen),
        .i_ren   (mem_ren),
        .i_size  (mem_size),
        .i_waddr (mem_waddr),
        .i_raddr (mem_raddr),
        .i_din   (mem_din),
        .o_dout  (mem_dout)
    );

    tb_checker u_checker (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_wen         (mem_wen),
        .i_ren         (mem_ren),
        .i_size        (mem_size),
        .i_waddr       (mem_waddr),
        .i_raddr       (mem_raddr),
        .i_din         (mem_din),
        .i_dout        (mem_dout),
        .i_test_id     (test_id),
        .i_test_done   (test_done),
        .o_error_count (error_count),
        .o_check_count (check_count)
    );

    // Called 2 ns after a rising edge and returns 2 ns after the next one
    task automatic drive(
        input logic                      wen,
        input logic [MEM_ADDR_WIDTH-1:0] waddr,
        input logic [DATA_WIDTH-1:0]     din,
        input logic                      ren,
        input logic [MEM_ADDR_WIDTH-1:0] raddr,
        input access_size_t              size
    );
        mem_wen   = wen;
        mem_waddr = waddr;
        mem_din   = din;
        mem_ren   = ren;
        mem_raddr = raddr;
        mem_size  = size;
        @(posedge clk);
        #2;
    endtask

    task automatic drive_idle();
        drive(1'b0, '0, '0, 1'b0, '0, SIZE_NONE);
    endtask

    // Idle cycles let the last read be checked inside its own test
    task automatic end_test(input logic [3:0] id);
        drive_idle();
        drive_idle();
        test_id   = id;
        test_done = 1'b1;
        drive_idle();
        test_done = 1'b0;
        tests_run = tests_run + 1;
    endtask

    task automatic fill_and_read_rows();
        logic [DATA_WIDTH-1:0] data;
        drive_idle();
        drive_idle();
        for (int row = 0; row < NUM_ROWS; row++) begin
            data = $random(seed);
            drive(1'b1, {row[ROW_ADDR_WIDTH-1:0], 2'b00}, data, 1'b0, '0, SIZE_WORD);
        end
        for (int row = 0; row < NUM_ROWS; row++) begin
            drive(1'b0, '0, '0, 1'b1, {row[ROW_ADDR_WIDTH-1:0], 2'b00}, SIZE_WORD);
        end
        end_test(4'd1);
    endtask

    task automatic random_bytes();
        logic [31:0]               r;
        logic [DATA_WIDTH-1:0]     data;
        logic [MEM_ADDR_WIDTH-1:0] wa;
        logic [MEM_ADDR_WIDTH-1:0] ra;
        logic [MEM_ADDR_WIDTH-1:0] last_wa;
        last_wa = '0;
        for (int i = 0; i < N_BYTE_OPS; i++) begin
            r    = $random(seed);
            data = $random(seed);
            wa   = $random(seed);
            ra   = $random(seed);
            // Often read back a recently written byte
            if (r[2]) begin
                ra = last_wa;
            end
            drive(r[0], wa, data, r[1] | r[3], ra, SIZE_BYTE);
            if (r[0]) begin
                last_wa = wa;
            end
        end
        end_test(4'd2);
    endtask

    task automatic unaligned_accesses();
        logic [31:0]               r;
        logic [DATA_WIDTH-1:0]     data;
        logic [MEM_ADDR_WIDTH-1:0] wa;
        logic [MEM_ADDR_WIDTH-1:0] ra;
        access_size_t              size;
        for (int i = 0; i < N_UNALIGNED_OPS; i++) begin
            r    = $random(seed);
            data = $random(seed);
            wa   = $random(seed);
            ra   = $random(seed);
            size = r[0] ? SIZE_WORD : SIZE_HALF;
            // A quarter of the writes start at 253..255 and wrap to row 0
            if (r[2:1] == 2'b00) begin
                wa = 8'd253 + {6'd0, (r[4:3] == 2'd3) ? 2'd0 : r[4:3]};
            end
            if (wa[1:0] == 2'b00) begin
                wa[0] = 1'b1;
            end
            if (r[6:5] == 2'b00) begin
                ra = wa;
            end
            if (ra[1:0] == 2'b00) begin
                ra[1] = 1'b1;
            end
            drive(r[7], wa, data, r[8] | r[9], ra, size);
        end
        end_test(4'd3);
    endtask

    task automatic size_none_accesses();
        logic [31:0]               r;
        logic [DATA_WIDTH-1:0]     data;
        logic [MEM_ADDR_WIDTH-1:0] wa;
        logic [MEM_ADDR_WIDTH-1:0] last_wa;
        access_size_t              size;
        last_wa = '0;
        for (int i = 0; i < N_NONE_OPS; i++) begin
            r    = $random(seed);
            data = $random(seed);
            wa   = $random(seed);
            size = access_size_t'((r[3:2] == 2'b00) ? 2'd3 : r[3:2]);
            case (r[1:0])
                2'd0: begin
                    drive(1'b1, wa, data, 1'b1, r[4] ? wa : last_wa, SIZE_NONE);
                    last_wa = wa;
                end
                2'd1: begin
                    drive(1'b0, wa, data, 1'b0, wa, size);
                end
                default: begin
                    // Bytes under a SIZE_NONE write must be unchanged
                    drive(1'b0, wa, data, 1'b1, last_wa, SIZE_WORD);
                end
            endcase
        end
        end_test(4'd4);
    endtask

    task automatic back_to_back_reads();
        logic [31:0]               r;
        logic [DATA_WIDTH-1:0]     data;
        logic [MEM_ADDR_WIDTH-1:0] addr;
        access_size_t              size;
        for (int i = 0; i < N_B2B_OPS; i++) begin
            r    = $random(seed);
            data = $random(seed);
            addr = $random(seed);
            size = access_size_t'((r[3:2] == 2'b00) ? 2'd1 : r[3:2]);
            drive(r[0] | r[1], addr, data, 1'b1, r[4] ? addr + 8'd1 : addr, size);
        end
        end_test(4'd5);
    endtask

    initial begin
        // Word read held through reset so that only reset keeps o_dout at zero
        mem_wen   = 1'b0;
        mem_ren   = 1'b1;
        mem_size  = SIZE_WORD;
        mem_waddr = '0;
        mem_raddr = '0;
        mem_din   = '0;
        test_id   = '0;
        test_done = 1'b0;
        tests_run = 0;

        // Reset drops 2 ns after an edge
        wait (reset === 1'b0);
        mem_ren  = 1'b0;
        mem_size = SIZE_NONE;

        fill_and_read_rows();
        random_bytes();
        unaligned_accesses();
        size_none_accesses();
        back_to_back_reads();

        $display("tests run: %0d, checks: %0d, errors: %0d",
                 tests_run, check_count, error_count);
        if ((error_count == 0) && (check_count > 0)) begin
            $display("No errors");
        end else begin
            if (check_count == 0) begin
                $display("the checker never compared any output");
            end
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
